//--- tb.f
icmp_proto_pkg.sv
icmp_ctrl_pkg.sv
icmp_checksum.sv
icmp_payload_ram.sv
icmp_rx_parser.sv
icmp_tx_framer.sv
icmp_echo.sv
tb_icmp_echo.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         ?= tb_icmp_echo
DUT_TOP     ?= icmp_echo
FILELIST    ?= tb.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_STRING ?= Finished with no errors
VFLAGS      ?= --binary --timing --assert -Wno-fatal
LINTFLAGS   ?= --lint-only --timing -Wall

SRCS := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_STRING)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_icmp_echo.sv
`timescale 1ns/1ps

module tb_icmp_echo;
    import icmp_ctrl_pkg::*;

    localparam int PAYLOAD_DEPTH = 256;
    localparam int TX_TIMEOUT    = 64;
    localparam int MAX_LEN       = 8 + PAYLOAD_DEPTH;
    localparam int NUM_TESTS     = 12;
    localparam int WAIT_LIMIT    = 40;      // cycles allowed for one handshake step
    localparam int QUIET_WINDOW  = 30;

    // fault kinds
    localparam int F_NONE     = 0;
    localparam int F_BAD_CSUM = 1;
    localparam int F_BAD_TYPE = 2;
    localparam int F_RX_ERROR = 3;

    logic  clk;
    logic  rstn;
    logic  rx_start;
    len_t  rx_len;
    byte_t rx_data;
    logic  rx_error;
    logic  tx_ack;
    logic  tx_data_req;
    logic  tx_req;
    logic  tx_valid;
    byte_t tx_data;
    logic  tx_end;

    // test table
    string       t_name   [NUM_TESTS];
    int          t_len    [NUM_TESTS];
    logic [15:0] t_id     [NUM_TESTS];
    logic [15:0] t_seq    [NUM_TESTS];
    int          t_fault  [NUM_TESTS];
    bit          t_answer [NUM_TESTS];  // IP side raises tx_data_req
    bit          t_reply  [NUM_TESTS];  // tx_req expected

    logic [7:0]  msg       [MAX_LEN];
    logic [7:0]  exp_reply [MAX_LEN];
    logic [31:0] rng_state;
    string       cur_name;
    int          err_cnt;
    int          failed_tests;

    icmp_echo #(
        .PAYLOAD_DEPTH (PAYLOAD_DEPTH),
        .TX_TIMEOUT    (TX_TIMEOUT)
    ) icmp_echo_i (
        .clk         (clk),
        .rstn        (rstn),
        .rx_start    (rx_start),
        .rx_len      (rx_len),
        .rx_data     (rx_data),
        .rx_error    (rx_error),
        .tx_ack      (tx_ack),
        .tx_data_req (tx_data_req),
        .tx_req      (tx_req),
        .tx_valid    (tx_valid),
        .tx_data     (tx_data),
        .tx_end      (tx_end)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic logic [7:0] next_random_byte();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[23:16];
    endfunction

    // ones-complement sum of 16-bit words, high byte first
    function automatic logic [15:0] ones_sum(input logic [7:0] data [MAX_LEN], input int len);
        int          i;
        logic [31:0] acc;
        logic [7:0]  lo;
        acc = '0;
        for (i = 0; i < len; i += 2)
        begin
            lo  = (i + 1 < len) ? data[i + 1] : 8'h00;     // odd tail padded
            acc = acc + {16'h0000, data[i], lo};
            acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};  // end-around carry
        end
        return acc[15:0];
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            $display("CHECK FAILED %s: %s expected 0x%0h, got 0x%0h",
                     cur_name, what, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic check_true(input bit ok, input string what);
        assert (ok)
        else
        begin
            $display("ERROR in %s: %s", cur_name, what);
            err_cnt++;
        end
    endtask

    task automatic add_row(input int idx, input string name, input int len,
                           input logic [15:0] id, input logic [15:0] seq,
                           input int fault, input bit answer, input bit reply);
        t_name[idx]   = name;
        t_len[idx]    = len;
        t_id[idx]     = id;
        t_seq[idx]    = seq;
        t_fault[idx]  = fault;
        t_answer[idx] = answer;
        t_reply[idx]  = reply;
    endtask

    task automatic fill_table();
        //      idx name              len  id        seq       fault       ans   reply
        add_row(0,  "even_len",       40,  16'h1234, 16'h0001, F_NONE,     1'b1, 1'b1);
        add_row(1,  "odd_len",        37,  16'habcd, 16'h0002, F_NONE,     1'b1, 1'b1);
        add_row(2,  "bad_csum",       24,  16'h0bad, 16'h0003, F_BAD_CSUM, 1'b1, 1'b0);
        add_row(3,  "after_bad_csum", 20,  16'h0bad, 16'h0004, F_NONE,     1'b1, 1'b1);
        add_row(4,  "bad_type",       16,  16'h7777, 16'h0005, F_BAD_TYPE, 1'b1, 1'b0);
        add_row(5,  "rx_error_mid",   30,  16'h5a5a, 16'h0006, F_RX_ERROR, 1'b1, 1'b0);
        add_row(6,  "after_rx_error", 22,  16'h5a5a, 16'h0007, F_NONE,     1'b1, 1'b1);
        add_row(7,  "no_data_req",    18,  16'hc0de, 16'h0008, F_NONE,     1'b0, 1'b1);
        add_row(8,  "after_timeout",  26,  16'hc0de, 16'h0009, F_NONE,     1'b1, 1'b1);
        add_row(9,  "header_only",    8,   16'h0042, 16'h000a, F_NONE,     1'b1, 1'b1);
        add_row(10, "full_buffer",    264, 16'hffff, 16'hfffe, F_NONE,     1'b1, 1'b1);
        add_row(11, "odd_short",      9,   16'h0001, 16'h8000, F_NONE,     1'b1, 1'b1);
    endtask

    ////////////////////////////////////////
    // message and expected reply
    ////////////////////////////////////////
    task automatic build_message(input int idx);
        int          i;
        int          len;
        logic [15:0] csum;
        len    = t_len[idx];
        msg[0] = (t_fault[idx] == F_BAD_TYPE) ? 8'h0d : 8'h08;    // type 13 is not echo
        msg[1] = next_random_byte();                               // code is echoed as is
        msg[2] = 8'h00;
        msg[3] = 8'h00;
        msg[4] = t_id[idx][15:8];
        msg[5] = t_id[idx][7:0];
        msg[6] = t_seq[idx][15:8];
        msg[7] = t_seq[idx][7:0];
        for (i = 8; i < MAX_LEN; i++)
        begin
            if (i < len)
                msg[i] = next_random_byte();
            else
                msg[i] = 8'h00;
        end
        csum   = ~ones_sum(msg, len);
        msg[2] = csum[15:8];
        msg[3] = csum[7:0];
        if (t_fault[idx] == F_BAD_CSUM)
            msg[3] = msg[3] ^ 8'h5a;

        // reply is type 0 with its own checksum
        exp_reply    = msg;
        exp_reply[0] = 8'h00;
        exp_reply[2] = 8'h00;
        exp_reply[3] = 8'h00;
        csum         = ~ones_sum(exp_reply, len);
        exp_reply[2] = csum[15:8];
        exp_reply[3] = csum[7:0];
    endtask

    task automatic send_message(input int len, input int fault);
        int i;
        @(posedge clk);
        rx_start <= 1'b1;
        rx_len   <= len_t'(len);
        for (i = 0; i < len; i++)
        begin
            @(posedge clk);
            rx_start <= 1'b0;
            rx_data  <= msg[i];
            rx_error <= (fault == F_RX_ERROR) && (i == len / 2);
        end
    endtask

    ////////////////////////////////////////
    // IP side model
    ////////////////////////////////////////
    task automatic wait_req_high(output int cycles, output bit seen);
        seen   = 1'b0;
        cycles = 0;
        @(negedge clk);     // still the last rx byte cycle
        while (!seen && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            seen = tx_req;
        end
        check_true(seen, "tx_req never rose after the message");
    endtask

    task automatic ack_request(output bit done);
        int n;
        @(posedge clk);
        tx_ack <= 1'b1;
        n    = 0;
        done = 1'b0;
        while (!done && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
            done = !tx_req;
        end
        check_true(done, "tx_req was not released after tx_ack");
        @(posedge clk);
        tx_ack <= 1'b0;
    endtask

    task automatic receive_reply(input int len);
        int n;
        int i;
        bit seen;
        @(posedge clk);
        tx_data_req <= 1'b1;
        n    = 0;
        seen = 1'b0;
        @(negedge clk);     // tx_data_req not sampled yet
        while (!seen && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
            seen = tx_valid;
        end
        check_true(seen, "tx_valid never rose after tx_data_req");
        if (seen)
        begin
            check_value("tx_data_req to tx_valid cycles", 2, n);
            for (i = 0; i < len; i++)
            begin
                check_true(tx_valid, $sformatf("tx_valid dropped before byte %0d", i));
                check_value($sformatf("byte %0d", i), int'(exp_reply[i]), int'(tx_data));
                check_value($sformatf("tx_end at byte %0d", i), (i == len - 1) ? 1 : 0,
                            int'(tx_end));
                @(negedge clk);
            end
            check_true(!tx_valid, "tx_valid stayed high past the last byte");
        end
        @(posedge clk);
        tx_data_req <= 1'b0;
    endtask

    task automatic check_no_request();
        int n;
        bit quiet;
        quiet = 1'b1;
        for (n = 0; n < QUIET_WINDOW; n++)
        begin
            @(negedge clk);
            if (tx_req)
                quiet = 1'b0;
        end
        check_true(quiet, "tx_req rose for a message that should be dropped");
    endtask

    task automatic check_no_stream();
        int n;
        bit quiet;
        quiet = 1'b1;
        for (n = 0; n < TX_TIMEOUT + 16; n++)   // covers the whole timeout
        begin
            @(negedge clk);
            if (tx_valid || tx_req)
                quiet = 1'b0;
        end
        check_true(quiet, "reply went out although tx_data_req never came");
    endtask

    task automatic run_test(input int idx);
        int lat;
        bit ok;
        send_message(t_len[idx], t_fault[idx]);
        if (!t_reply[idx])
        begin
            check_no_request();
            return;
        end
        wait_req_high(lat, ok);
        if (!ok)
            return;
        check_value("last rx byte to tx_req cycles", 4, lat);
        ack_request(ok);
        if (!ok)
            return;
        if (t_answer[idx])
            receive_reply(t_len[idx]);
        else
            check_no_stream();
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial
    begin
        int i;
        int err_before;
        rstn         = 1'b0;
        rx_start     = 1'b0;
        rx_len       = '0;
        rx_data      = '0;
        rx_error     = 1'b0;
        tx_ack       = 1'b0;
        tx_data_req  = 1'b0;
        rng_state    = 32'h7619_f71b;
        err_cnt      = 0;
        failed_tests = 0;
        fill_table();

        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        repeat (4) @(posedge clk);

        for (i = 0; i < NUM_TESTS; i++)
        begin
            cur_name   = t_name[i];
            err_before = err_cnt;
            build_message(i);
            run_test(i);
            if (err_cnt == err_before)
                $display("test %-16s passed", cur_name);
            else
            begin
                failed_tests++;
                $display("test %-16s failed", cur_name);
            end
            repeat (8) @(posedge clk);  // lets reply_ack settle before the next start
        end

        $display("%0d tests run, %0d failed, %0d failed checks",
                 NUM_TESTS, failed_tests, err_cnt);
        if (err_cnt == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- icmp_echo.sv
`timescale 1ns/1ps

module icmp_echo #(
    parameter int PAYLOAD_DEPTH = 256,
    parameter int TX_TIMEOUT    = 1024
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 rx_start,
    input  icmp_ctrl_pkg::len_t  rx_len,
    input  icmp_ctrl_pkg::byte_t rx_data,
    input  logic                 rx_error,
    input  logic                 tx_ack,
    input  logic                 tx_data_req,
    output logic                 tx_req,
    output logic                 tx_valid,
    output icmp_ctrl_pkg::byte_t tx_data,
    output logic                 tx_end
);
    import icmp_ctrl_pkg::*;

    localparam int AW = $clog2(PAYLOAD_DEPTH);

    // payload buffer
    logic          wr_en;
    logic [AW-1:0] wr_addr;
    byte_t         wr_data;
    logic [AW-1:0] rd_addr;
    byte_t         rd_data;

    // checksum feeds
    logic          chk_clear;
    logic          chk_add;
    csum_t         chk_word;
    csum_t         chk_sum;
    logic          rep_clear;
    logic          rep_add;
    csum_t         rep_word;
    csum_t         rep_sum;

    // parser to framer
    logic          reply_req;
    logic          reply_ack;
    byte_t         code;
    logic [15:0]   id;
    logic [15:0]   seq;
    len_t          msg_len;

    icmp_rx_parser #(
        .PAYLOAD_DEPTH (PAYLOAD_DEPTH)
    ) rx_parser (
        .clk       (clk),
        .rstn      (rstn),
        .rx_start  (rx_start),
        .rx_len    (rx_len),
        .rx_data   (rx_data),
        .rx_error  (rx_error),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .chk_clear (chk_clear),
        .chk_add   (chk_add),
        .chk_word  (chk_word),
        .rep_clear (rep_clear),
        .rep_add   (rep_add),
        .rep_word  (rep_word),
        .chk_sum   (chk_sum),
        .reply_req (reply_req),
        .reply_ack (reply_ack),
        .code      (code),
        .id        (id),
        .seq       (seq),
        .msg_len   (msg_len)
    );

    icmp_checksum verify_csum (
        .clk    (clk),
        .rstn   (rstn),
        .clear  (chk_clear),
        .add_en (chk_add),
        .word   (chk_word),
        .sum    (chk_sum)
    );

    icmp_checksum reply_csum (
        .clk    (clk),
        .rstn   (rstn),
        .clear  (rep_clear),
        .add_en (rep_add),
        .word   (rep_word),
        .sum    (rep_sum)
    );

    icmp_payload_ram #(
        .PAYLOAD_DEPTH (PAYLOAD_DEPTH)
    ) payload_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    icmp_tx_framer #(
        .PAYLOAD_DEPTH (PAYLOAD_DEPTH),
        .TX_TIMEOUT    (TX_TIMEOUT)
    ) tx_framer (
        .clk         (clk),
        .rstn        (rstn),
        .reply_req   (reply_req),
        .reply_ack   (reply_ack),
        .code        (code),
        .id          (id),
        .seq         (seq),
        .msg_len     (msg_len),
        .reply_csum  (rep_sum),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .tx_req      (tx_req),
        .tx_ack      (tx_ack),
        .tx_data_req (tx_data_req),
        .tx_valid    (tx_valid),
        .tx_data     (tx_data),
        .tx_end      (tx_end)
    );

endmodule

//--- icmp_tx_framer.sv
`timescale 1ns/1ps

module icmp_tx_framer #(
    parameter int PAYLOAD_DEPTH = 256,
    parameter int TX_TIMEOUT    = 1024
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             reply_req,
    output logic                             reply_ack,
    input  icmp_ctrl_pkg::byte_t             code,
    input  logic [15:0]                      id,
    input  logic [15:0]                      seq,
    input  icmp_ctrl_pkg::len_t              msg_len,
    input  icmp_ctrl_pkg::csum_t             reply_csum,
    output logic [$clog2(PAYLOAD_DEPTH)-1:0] rd_addr,
    input  icmp_ctrl_pkg::byte_t             rd_data,
    output logic                             tx_req,
    input  logic                             tx_ack,
    input  logic                             tx_data_req,
    output logic                             tx_valid,
    output icmp_ctrl_pkg::byte_t             tx_data,
    output logic                             tx_end
);
    import icmp_ctrl_pkg::*;
    import icmp_proto_pkg::*;

    localparam int AW = $clog2(PAYLOAD_DEPTH);
    localparam int TW = $clog2(TX_TIMEOUT + 1);

    tx_state_t     state;
    len_t          cnt;         // index of the byte being sent
    len_t          rd_idx;
    logic [TW-1:0] wait_cnt;
    logic          last;
    byte_t         next_byte;

    // payload read runs one byte ahead to cover the RAM latency
    assign rd_idx  = cnt - len_t'(HDR_LEN) + len_t'(1);
    assign rd_addr = rd_idx[AW-1:0];
    assign last    = (cnt == msg_len - len_t'(1));

    always_comb
    begin
        case (cnt)
            len_t'(OFS_TYPE):     next_byte = ECHO_REPLY;
            len_t'(OFS_CODE):     next_byte = code;
            len_t'(OFS_CSUM):     next_byte = reply_csum[15:8];
            len_t'(OFS_CSUM + 1): next_byte = reply_csum[7:0];
            len_t'(OFS_ID):       next_byte = id[15:8];
            len_t'(OFS_ID + 1):   next_byte = id[7:0];
            len_t'(OFS_SEQ):      next_byte = seq[15:8];
            len_t'(OFS_SEQ + 1):  next_byte = seq[7:0];
            default:              next_byte = rd_data;
        endcase
    end

    ////////////////////////////////////////
    // handshake and stream control
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state     <= TX_IDLE;
            reply_ack <= 1'b0;
            tx_req    <= 1'b0;
            tx_valid  <= 1'b0;
            tx_end    <= 1'b0;
            cnt       <= '0;
            wait_cnt  <= '0;
        end
        else
        begin
            tx_valid <= 1'b0;
            tx_end   <= 1'b0;
            case (state)
                TX_IDLE:
                begin
                    if (!reply_req)
                        reply_ack <= 1'b0;      // parser has let go
                    else if (!reply_ack)
                    begin
                        state  <= TX_REQ;
                        tx_req <= 1'b1;
                    end
                end
                TX_REQ:
                    if (tx_ack)
                    begin
                        tx_req <= 1'b0;
                        state  <= TX_REL;
                    end
                TX_REL:
                    if (!tx_ack)
                    begin
                        wait_cnt <= '0;
                        state    <= TX_WAIT;
                    end
                TX_WAIT:
                begin
                    if (tx_data_req)
                    begin
                        cnt   <= '0;
                        state <= TX_SEND;
                    end
                    else if (wait_cnt == TW'(TX_TIMEOUT - 1))
                    begin
                        reply_ack <= 1'b1;      // give up, reply is lost
                        state     <= TX_IDLE;
                    end
                    else
                        wait_cnt <= wait_cnt + 1'b1;
                end
                TX_SEND:
                begin
                    tx_valid <= 1'b1;
                    tx_end   <= last;
                    cnt      <= cnt + len_t'(1);
                    if (last)
                    begin
                        reply_ack <= 1'b1;
                        state     <= TX_IDLE;
                    end
                end
                default:
                    state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == TX_SEND)
            tx_data <= next_byte;
    end

    // request is held for as long as the IP side takes to answer
    assert property (@(posedge clk) disable iff (!rstn) tx_req && !tx_ack |=> tx_req)
        else $error("icmp_tx_framer: tx_req dropped before tx_ack");

endmodule

//--- icmp_rx_parser.sv
`timescale 1ns/1ps

module icmp_rx_parser #(
    parameter int PAYLOAD_DEPTH = 256
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             rx_start,
    input  icmp_ctrl_pkg::len_t              rx_len,
    input  icmp_ctrl_pkg::byte_t             rx_data,
    input  logic                             rx_error,
    output logic                             wr_en,
    output logic [$clog2(PAYLOAD_DEPTH)-1:0] wr_addr,
    output icmp_ctrl_pkg::byte_t             wr_data,
    output logic                             chk_clear,
    output logic                             chk_add,
    output icmp_ctrl_pkg::csum_t             chk_word,
    output logic                             rep_clear,
    output logic                             rep_add,
    output icmp_ctrl_pkg::csum_t             rep_word,
    input  icmp_ctrl_pkg::csum_t             chk_sum,
    output logic                             reply_req,
    input  logic                             reply_ack,
    output icmp_ctrl_pkg::byte_t             code,
    output logic [15:0]                      id,
    output logic [15:0]                      seq,
    output icmp_ctrl_pkg::len_t              msg_len
);
    import icmp_ctrl_pkg::*;
    import icmp_proto_pkg::*;

    localparam int AW = $clog2(PAYLOAD_DEPTH);

    rx_state_t state;
    len_t      cnt;         // bytes taken so far
    len_t      pay_idx;
    len_t      word_ofs;    // offset of the high byte of the current word
    byte_t     hi_byte;
    logic      type_ok;
    logic      len_ok;
    logic      byte_vld;
    logic      last_byte;
    logic      word_done;
    logic      start_ok;
    logic      sum_clear;
    logic      sum_add;
    csum_t     word;
    csum_t     word_rep;

    assign start_ok  = (state == RX_IDLE) && rx_start && !reply_ack;
    assign byte_vld  = (state == RX_RECV) && (cnt < msg_len);
    assign last_byte = byte_vld && (cnt == msg_len - len_t'(1));
    assign word_done = byte_vld && (cnt[0] || last_byte);
    assign pay_idx   = cnt - len_t'(HDR_LEN);
    assign word_ofs  = {cnt[15:1], 1'b0};
    assign len_ok    = (msg_len >= len_t'(HDR_LEN)) &&
                       (32'(msg_len) <= 32'(HDR_LEN + PAYLOAD_DEPTH));

    // both sums are cleared and fed in step
    assign chk_clear = sum_clear;
    assign rep_clear = sum_clear;
    assign chk_add   = sum_add;
    assign rep_add   = sum_add;
    assign reply_req = (state == RX_READY);

    ////////////////////////////////////////
    // word pairing
    ////////////////////////////////////////
    always_comb
    begin
        word = {hi_byte, rx_data};
        if (!cnt[0])
            word = {rx_data, 8'h00};        // odd tail, zero pad
        word_rep = word;
        if (word_ofs == len_t'(OFS_TYPE))
            word_rep = {ECHO_REPLY, word[7:0]};
        else if (word_ofs == len_t'(OFS_CSUM))
            word_rep = '0;                  // reply checksum field taken as zero
    end

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state     <= RX_IDLE;
            cnt       <= '0;
            type_ok   <= 1'b0;
            sum_clear <= 1'b0;
            sum_add   <= 1'b0;
            wr_en     <= 1'b0;
        end
        else
        begin
            sum_clear <= start_ok;
            sum_add   <= word_done;
            wr_en     <= byte_vld && (cnt >= len_t'(HDR_LEN)) &&
                         (pay_idx < len_t'(PAYLOAD_DEPTH));
            if (start_ok)
            begin
                cnt     <= '0;
                type_ok <= 1'b0;
            end
            else if (byte_vld)
            begin
                cnt <= cnt + len_t'(1);
                if (cnt == len_t'(OFS_TYPE))
                    type_ok <= (rx_data == ECHO_REQUEST);
            end

            case (state)
                RX_IDLE:
                    if (start_ok)
                        state <= RX_RECV;
                RX_RECV:
                    if (rx_error)
                        state <= RX_DROP;
                    else if (cnt == msg_len)
                        state <= RX_CHECK;      // last add is in flight this cycle
                RX_CHECK:
                    if (type_ok && len_ok && (chk_sum == '0))
                        state <= RX_READY;
                    else
                        state <= RX_DROP;
                RX_READY:
                    if (reply_ack)
                        state <= RX_IDLE;
                default:
                    state <= RX_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // captured fields and datapath
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (start_ok)
            msg_len <= rx_len;
        if (byte_vld)
        begin
            if (!cnt[0])
                hi_byte <= rx_data;
            if (cnt == len_t'(OFS_CODE))
                code <= rx_data;
            if (cnt == len_t'(OFS_ID))
                id[15:8] <= rx_data;
            if (cnt == len_t'(OFS_ID + 1))
                id[7:0] <= rx_data;
            if (cnt == len_t'(OFS_SEQ))
                seq[15:8] <= rx_data;
            if (cnt == len_t'(OFS_SEQ + 1))
                seq[7:0] <= rx_data;
        end
        if (word_done)
        begin
            chk_word <= word;
            rep_word <= word_rep;
        end
        wr_addr <= pay_idx[AW-1:0];
        wr_data <= rx_data;
    end

endmodule

//--- icmp_payload_ram.sv
`timescale 1ns/1ps

module icmp_payload_ram #(
    parameter int PAYLOAD_DEPTH = 256
) (
    input  logic                             clk,
    input  logic                             wr_en,
    input  logic [$clog2(PAYLOAD_DEPTH)-1:0] wr_addr,
    input  icmp_ctrl_pkg::byte_t             wr_data,
    input  logic [$clog2(PAYLOAD_DEPTH)-1:0] rd_addr,
    output icmp_ctrl_pkg::byte_t             rd_data
);
    import icmp_ctrl_pkg::*;

    byte_t mem [PAYLOAD_DEPTH];     // echo payload, header bytes not stored

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];    // one cycle read latency
    end

    // writer side must keep oversized messages out of the buffer
    assert property (@(posedge clk) wr_en |-> (int'(wr_addr) < PAYLOAD_DEPTH))
        else $error("icmp_payload_ram: write address %0d out of range", wr_addr);

endmodule

//--- icmp_checksum.sv
`timescale 1ns/1ps

module icmp_checksum (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 clear,
    input  logic                 add_en,
    input  icmp_ctrl_pkg::csum_t word,
    output icmp_ctrl_pkg::csum_t sum
);
    import icmp_ctrl_pkg::*;

    logic [31:0] acc;       // running sum, carries kept in upper half
    logic [31:0] acc_next;
    logic [31:0] fold_1;
    logic [31:0] fold_2;
    csum_t       folded;

    always_comb
    begin
        acc_next = acc;
        if (clear)
            acc_next = '0;
        else if (add_en)
            acc_next = acc + {16'h0000, word};
        // two end-around folds are always enough for 32 bits
        fold_1 = {16'h0000, acc_next[31:16]} + {16'h0000, acc_next[15:0]};
        fold_2 = {16'h0000, fold_1[31:16]} + {16'h0000, fold_1[15:0]};
    end

    assign folded = fold_2[15:0];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            acc <= '0;
            sum <= 16'hffff;
        end
        else
        begin
            acc <= acc_next;
            sum <= ~folded;     // ready the cycle after the last add
        end
    end

    // the parser must never restart a sum while still feeding it
    assert property (@(posedge clk) disable iff (!rstn) !(clear && add_en))
        else $error("icmp_checksum: clear and add_en high together");

endmodule

//--- icmp_ctrl_pkg.sv
package icmp_ctrl_pkg;

    // datapath words
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] len_t;     // byte count of a message
    typedef logic [15:0] csum_t;    // ones-complement word

    ////////////////////////////////////////
    // receive FSM
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_RECV,
        RX_CHECK,
        RX_READY,     // holding reply_req toward the framer
        RX_DROP
    } rx_state_t;

    ////////////////////////////////////////
    // transmit FSM
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_REQ,       // tx_req high, waiting for tx_ack
        TX_REL,       // waiting for tx_ack to drop
        TX_WAIT,      // waiting for tx_data_req
        TX_SEND
    } tx_state_t;

endpackage

//--- icmp_proto_pkg.sv
package icmp_proto_pkg;

    ////////////////////////////////////////
    // message type codes
    ////////////////////////////////////////
    localparam logic [7:0] ECHO_REQUEST = 8'h08;
    localparam logic [7:0] ECHO_REPLY   = 8'h00;

    ////////////////////////////////////////
    // header layout, byte offsets
    ////////////////////////////////////////
    localparam int HDR_LEN = 8;     // type, code, checksum, id, seq

    localparam int OFS_TYPE = 0;
    localparam int OFS_CODE = 1;
    localparam int OFS_CSUM = 2;    // two bytes, high first
    localparam int OFS_ID   = 4;    // two bytes, high first
    localparam int OFS_SEQ  = 6;    // two bytes, high first

endpackage
